/* list.f */
+incdir+include
verilog/ddr_ctrl_pkg.sv
verilog/apb_req_port.sv
verilog/refresh_timer.sv
verilog/ddr_cmd_seq.sv
verilog/dq_burst.sv
verilog/ddr_ctrl_top.sv
dv/ddr_ctrl_props.sv
dv/ddr_ctrl_tb.sv

/* Bender.yml */
package:
  name: ddr_ctrl

sources:
  - include_dirs:
      - include
    files:
      - verilog/ddr_ctrl_pkg.sv
      - verilog/apb_req_port.sv
      - verilog/refresh_timer.sv
      - verilog/ddr_cmd_seq.sv
      - verilog/dq_burst.sv
      - verilog/ddr_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/ddr_ctrl_props.sv
      - dv/ddr_ctrl_tb.sv

/* dv/ddr_ctrl_tb.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module ddr_ctrl_tb;

    import ddr_ctrl_pkg::*;

    localparam int N_OPS   = 13;
    localparam int REF_MAX = `REF_INTERVAL + `T_RFC + `T_RCD + `T_WL + 12;
    // Table plus the stall and error tests
    localparam int MAX_CYC = 10 + `T_INIT_RST + `T_ZQ
                           + (N_OPS + 2) * (`T_RCD + `T_WL + `DDR_BURST + `T_RFC + 40);

    logic                   CLK;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata;
    logic [`APB_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   ddr_reset_n;
    ddr_cmd_t               cmd;
    dq_bus_t                dq;
    logic [`DDR_DQ_W-1:0]   dq_in;
    logic [`DDR_DQ_W-1:0]   dq_in_nx = '0;  // Model byte for the next cycle
    logic [3:0]             pins;           // {cs_n, ras_n, cas_n, we_n}

    int          cyc = 0;
    int          n_mismatch = 0;
    int          n_other = 0;
    mem_req_t    ops [N_OPS];               // Operation table
    logic [31:0] exp_mem [logic [27:0]];    // Scoreboard, {ba, row, col}
    logic [31:0] mem [logic [27:0]];        // DRAM model contents

    ddr_ctrl_top dut0 (
        .CLK(CLK), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .ddr_reset_n(ddr_reset_n), .cmd(cmd), .dq(dq), .dq_in(dq_in)
    );

    assign pins = {cmd.cs_n, cmd.ras_n, cmd.cas_n, cmd.we_n};

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;     // 20 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        n_mismatch++;
        $display("mismatch at %0t: %s expected %h, actual %h", $time, sig, exp_v, act_v);
    endtask

    task automatic report_failure(input string msg);
        n_other++;
        $display("error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // APB master
    ////////////////////////////////////////////////////////////
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, output int stalls);
        stalls = 0;
        @(posedge CLK);
        psel    <= 1'b1;        // Setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);         // Slave outputs settled
        while (!pready) begin
            stalls++;           // Held off by a busy port
            @(negedge CLK);
        end
        if (pslverr !== exp_err)
            report_mismatch("pslverr", exp_err, pslverr);
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, input logic exp_err,
                            output logic [31:0] data);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        while (!pready)
            @(negedge CLK);
        data = prdata;
        if (pslverr !== exp_err)
            report_mismatch("pslverr", exp_err, pslverr);
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] d;
        do
            apb_read(`REG_STATUS, 1'b0, d);
        while (d[0]);           // Busy bit
    endtask

    ////////////////////////////////////////////////////////////
    // DRAM model and bus checks
    ////////////////////////////////////////////////////////////
    logic        pwr_done = 1'b0;
    int          rst_low_cyc = 0;
    int          ref_gap = 0;
    int          ref_seen = 0;
    int          act_cyc = 0;
    logic [14:0] act_row;
    logic [2:0]  act_ba;
    logic [27:0] col_key;       // Address of the last column command
    logic        col_wr;
    logic        col_busy = 1'b0;
    int          col_j;         // Cycles since the column command
    logic        in_wr_beat;    // This cycle is a write beat
    logic [31:0] model_wr_word;
    logic [31:0] model_rd_word;
    logic [31:0] rng = 32'd87255;

    // Pins sampled mid cycle where they are stable
    always @(negedge CLK) begin
        if (!rst) begin
            in_wr_beat = 1'b0;
            if (!pwr_done) begin
                if (!ddr_reset_n) begin
                    rst_low_cyc = rst_low_cyc + 1;
                end else begin
                    pwr_done = 1'b1;
                    if (rst_low_cyc != `T_INIT_RST)
                        report_mismatch("ddr_reset_n low cycles", `T_INIT_RST, rst_low_cyc);
                    if (pins != ZQCL)
                        report_mismatch("cmd after DRAM reset", ZQCL, pins);
                end
            end else begin
                ref_gap = ref_gap + 1;
                if (ref_gap == REF_MAX)
                    report_failure("no REF within the refresh window");
            end
            if (pins == REF) begin
                ref_seen = ref_seen + 1;
                ref_gap  = 0;
            end
            if (pins == ACT) begin
                act_cyc = cyc;
                act_row = cmd.addr;
                act_ba  = cmd.ba;
            end
            if (pins == WR || pins == RD) begin
                if (cyc - act_cyc != `T_RCD)
                    report_mismatch("ACT to column cycles", `T_RCD, cyc - act_cyc);
                if (cmd.ba != act_ba)
                    report_mismatch("column bank", act_ba, cmd.ba);
                if (cmd.addr[10] || cmd.addr[12])
                    report_failure("column command with A10 or A12 set");
                col_key  = {cmd.ba, act_row, cmd.addr[9:0]};
                col_wr   = (pins == WR);
                col_j    = 0;
                col_busy = 1'b1;
                if (!col_wr) begin
                    if (!mem.exists(col_key)) begin
                        rng          = xorshift32(rng);
                        mem[col_key] = rng;   // Remembered for later reads
                    end
                    model_rd_word = mem[col_key];
                end
            end else if (col_busy) begin
                col_j = col_j + 1;
                // Write beats, LSB first
                if (col_wr && col_j >= `T_WL && col_j < `T_WL + `DDR_BURST) begin
                    in_wr_beat = 1'b1;
                    if (!dq.oe || dq.dm)
                        report_failure("write beat without output enable or with mask high");
                    model_wr_word[8*(col_j-`T_WL) +: 8] = dq.data;
                    if (col_j == `T_WL + `DDR_BURST - 1)
                        mem[col_key] = model_wr_word;
                end
                // Byte goes on the lane at the next rising edge
                if (!col_wr && col_j >= `T_RL - 1 && col_j < `T_RL - 1 + `DDR_BURST)
                    dq_in_nx = model_rd_word[8*(col_j-`T_RL+1) +: 8];
                else
                    dq_in_nx = '0;
                if (col_j == (col_wr ? `T_WL : `T_RL) + `DDR_BURST) begin
                    col_busy = 1'b0;
                    if (pins != PRE)
                        report_mismatch("cmd after last beat", PRE, pins);
                    if (cmd.ba != col_key[27:25])
                        report_mismatch("PRE bank", col_key[27:25], cmd.ba);
                end
            end
            if (!in_wr_beat && (dq.oe || !dq.dm))
                report_failure("output enable high or mask low outside a write beat");
        end
    end

    always @(posedge CLK)
        dq_in <= dq_in_nx;

    // Cycle count and timeout
    always @(posedge CLK) begin
        cyc <= cyc + 1;
        if (cyc == MAX_CYC) begin
            $display("Timeout after %0d cycles, errors: %0d mismatch, %0d other",
                     cyc, n_mismatch, n_other);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] rdata;
        logic [31:0] exp_word;
        logic [27:0] key;
        int          stalls;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        dq_in   = '0;
        //              write  ba    row       col      wdata
        ops[0]  = '{1'b1, 3'd1, 15'h0123, 10'h010, 32'hDEADBEEF};
        ops[1]  = '{1'b0, 3'd1, 15'h0123, 10'h010, 32'h0};
        ops[2]  = '{1'b1, 3'd3, 15'h7FFF, 10'h3F8, 32'h12345678};
        ops[3]  = '{1'b1, 3'd1, 15'h0123, 10'h010, 32'hA5A55A5A};  // Overwrite
        ops[4]  = '{1'b0, 3'd3, 15'h7FFF, 10'h3F8, 32'h0};
        ops[5]  = '{1'b0, 3'd1, 15'h0123, 10'h010, 32'h0};
        ops[6]  = '{1'b0, 3'd0, 15'h0042, 10'h020, 32'h0};         // Never written
        ops[7]  = '{1'b1, 3'd7, 15'h1000, 10'h000, 32'hCAFEF00D};
        ops[8]  = '{1'b0, 3'd0, 15'h0042, 10'h020, 32'h0};
        ops[9]  = '{1'b0, 3'd7, 15'h1000, 10'h000, 32'h0};
        ops[10] = '{1'b1, 3'd2, 15'h0042, 10'h020, 32'h0BADC0DE};  // Same row, other bank
        ops[11] = '{1'b0, 3'd2, 15'h0042, 10'h020, 32'h0};
        ops[12] = '{1'b0, 3'd0, 15'h0042, 10'h020, 32'h0};
        repeat (10) @(posedge CLK);
        rst <= 1'b0;

        do
            apb_read(`REG_STATUS, 1'b0, rdata);
        while (!rdata[1]);
        if (rdata[1:0] != 2'b10)
            report_mismatch("STATUS after init", 32'h2, rdata);

        for (int i = 0; i < N_OPS; i++) begin
            key = {ops[i].ba, ops[i].row, ops[i].col};
            apb_write(`REG_ROWBANK, {13'b0, ops[i].ba, 1'b0, ops[i].row}, 1'b0, stalls);
            apb_write(`REG_COL, {22'b0, ops[i].col}, 1'b0, stalls);
            if (ops[i].write) begin
                apb_write(`REG_WDATA, ops[i].wdata, 1'b0, stalls);
                exp_mem[key] = ops[i].wdata;
            end
            apb_write(`REG_CMD, {31'b0, ops[i].write}, 1'b0, stalls);
            wait_idle();
            if (col_key != key)
                report_mismatch("DRAM address", key, col_key);
            if (!ops[i].write) begin
                apb_read(`REG_RDATA, 1'b0, rdata);
                exp_word = exp_mem.exists(key) ? exp_mem[key] : mem[key];
                if (rdata != exp_word)
                    report_mismatch("REG_RDATA", exp_word, rdata);
            end
        end

        // Command write while busy, then read back
        apb_write(`REG_ROWBANK, {13'b0, 3'd5, 1'b0, 15'h2A2A}, 1'b0, stalls);
        apb_write(`REG_COL, {22'b0, 10'h155}, 1'b0, stalls);
        apb_write(`REG_WDATA, 32'h600DF00D, 1'b0, stalls);
        apb_write(`REG_CMD, 32'h1, 1'b0, stalls);
        apb_write(`REG_CMD, 32'h0, 1'b0, stalls);
        if (stalls == 0)
            report_failure("second command write was not stalled while busy");
        wait_idle();
        apb_read(`REG_RDATA, 1'b0, rdata);
        if (rdata != 32'h600DF00D)
            report_mismatch("REG_RDATA after stall", 32'h600DF00D, rdata);

        // Unmapped offset
        apb_write(8'h18, 32'hFFFF_FFFF, 1'b1, stalls);
        apb_read(8'h18, 1'b1, rdata);
        apb_read(`REG_ROWBANK, 1'b0, rdata);
        if (rdata != {13'b0, 3'd5, 1'b0, 15'h2A2A})
            report_mismatch("REG_ROWBANK", {13'b0, 3'd5, 1'b0, 15'h2A2A}, rdata);
        apb_read(`REG_COL, 1'b0, rdata);
        if (rdata != 32'h155)
            report_mismatch("REG_COL", 32'h155, rdata);
        apb_read(`REG_WDATA, 1'b0, rdata);
        if (rdata != 32'h600DF00D)
            report_mismatch("REG_WDATA", 32'h600DF00D, rdata);

        while (ref_seen == 0)
            @(posedge CLK);     // At least one refresh
        repeat (`T_RFC + 2) @(posedge CLK);

        $display("Errors: %0d mismatch, %0d other, %0d assertion",
                 n_mismatch, n_other, dut0.u_props.fail_cnt);
        if (n_mismatch + n_other + dut0.u_props.fail_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* dv/ddr_ctrl_props.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module ddr_ctrl_props (
    input logic                   CLK,
    input logic                   rst,
    input logic                   ddr_reset_n,
    input ddr_ctrl_pkg::ddr_cmd_t cmd,
    input ddr_ctrl_pkg::dq_bus_t  dq
);

    import ddr_ctrl_pkg::*;

    logic [3:0] pins;
    logic       is_nop;
    logic       is_col;     // WR or RD
    logic       is_wr;
    int         fail_cnt = 0;

    assign pins   = {cmd.cs_n, cmd.ras_n, cmd.cas_n, cmd.we_n};
    assign is_nop = (pins == NOP);
    assign is_wr  = (pins == WR);
    assign is_col = (pins == WR) || (pins == RD);

    ////////////////////////////////////////////////////////////
    // DRAM command timing
    ////////////////////////////////////////////////////////////
    rfc_quiet: assert property (@(posedge CLK) disable iff (rst)
        (pins == REF) |=> is_nop [*`T_RFC])
        else begin $error("command issued inside tRFC"); fail_cnt++; end

    rcd_exact: assert property (@(posedge CLK) disable iff (rst)
        (pins == ACT) |=> !is_col [*(`T_RCD-1)] ##1 is_col)
        else begin $error("column command not tRCD after ACT"); fail_cnt++; end

    // Drive only in the four write beats
    oe_in_burst: assert property (@(posedge CLK) disable iff (rst)
        dq.oe |-> ($past(is_wr, `T_WL) || $past(is_wr, `T_WL+1) ||
                   $past(is_wr, `T_WL+2) || $past(is_wr, `T_WL+3)))
        else begin $error("output enable outside a write burst"); fail_cnt++; end

    cs_in_reset: assert property (@(posedge CLK) disable iff (rst)
        !ddr_reset_n |-> cmd.cs_n)
        else begin $error("chip select active while DRAM reset low"); fail_cnt++; end

endmodule

bind ddr_ctrl_top ddr_ctrl_props u_props (
    .CLK(CLK), .rst(rst), .ddr_reset_n(ddr_reset_n), .cmd(cmd), .dq(dq)
);

/* verilog/ddr_ctrl_top.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module ddr_ctrl_top (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic [`APB_DATA_W-1:0]  pwdata,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    output logic                    ddr_reset_n,
    output ddr_ctrl_pkg::ddr_cmd_t  cmd,
    output ddr_ctrl_pkg::dq_bus_t   dq,
    input  logic [`DDR_DQ_W-1:0]    dq_in
);

    import ddr_ctrl_pkg::*;

    logic                   init_done;
    logic                   req_valid;
    logic                   req_ready;
    logic                   req_done;
    mem_req_t               req;
    logic                   ref_req;
    logic                   ref_ack;
    burst_ctl_t             burst;
    logic                   burst_done;
    logic                   rd_valid;
    logic [`APB_DATA_W-1:0] rd_word;

    ////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////
    apb_req_port u_port (
        .CLK(CLK), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr),
        .init_done(init_done),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .req_done(req_done), .rd_valid(rd_valid), .rd_word(rd_word)
    );

    refresh_timer u_ref (
        .CLK(CLK), .rst(rst),
        .init_done(init_done), .ref_req(ref_req), .ref_ack(ref_ack)
    );

    ////////////////////////////////////////////////////////////
    // DRAM side
    ////////////////////////////////////////////////////////////
    ddr_cmd_seq u_seq (
        .CLK(CLK), .rst(rst),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .req_done(req_done), .ref_req(ref_req), .ref_ack(ref_ack),
        .burst(burst), .burst_done(burst_done),
        .ddr_reset_n(ddr_reset_n), .cmd(cmd), .init_done(init_done)
    );

    dq_burst u_dq (
        .CLK(CLK), .rst(rst),
        .burst(burst), .dq(dq), .dq_in(dq_in),
        .burst_done(burst_done), .rd_valid(rd_valid), .rd_word(rd_word)
    );

endmodule

/* verilog/dq_burst.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module dq_burst (
    input  logic                     CLK,
    input  logic                     rst,
    input  ddr_ctrl_pkg::burst_ctl_t burst,
    output ddr_ctrl_pkg::dq_bus_t    dq,
    input  logic [`DDR_DQ_W-1:0]     dq_in,
    output logic                     burst_done,
    output logic                     rd_valid,
    output logic [`APB_DATA_W-1:0]   rd_word
);

    localparam int LAT_W  = $clog2(`T_WL);     // T_WL is the longer latency
    localparam int BEAT_W = $clog2(`DDR_BURST);

    logic                   in_lat;     // Counting latency
    logic                   in_beat;    // Data beats on the lane
    logic                   wr_q;
    logic [LAT_W-1:0]       lat_cnt;
    logic [BEAT_W-1:0]      beat_cnt;
    logic [`APB_DATA_W-1:0] shreg;      // Byte 0 sits at the bottom
    logic [`DDR_DQ_W-1:0]   byte_in;
    logic                   last_beat;
    logic                   wr_beat;

    assign last_beat = in_beat && (beat_cnt == BEAT_W'(`DDR_BURST - 1));
    assign wr_beat   = in_beat && wr_q;
    assign byte_in   = wr_q ? '0 : dq_in;  // Writes just drain

    ////////////////////////////////////////////////////////////
    // Latency and beat control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            in_lat     <= 1'b0;
            in_beat    <= 1'b0;
            wr_q       <= 1'b0;
            lat_cnt    <= '0;
            beat_cnt   <= '0;
            burst_done <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            burst_done <= last_beat;
            rd_valid   <= last_beat && !wr_q;
            if (burst.start) begin
                in_lat  <= 1'b1;
                wr_q    <= burst.write;
                // First beat lands latency cycles after the command
                lat_cnt <= burst.write ? LAT_W'(`T_WL - 2) : LAT_W'(`T_RL - 2);
            end else if (in_lat) begin
                if (lat_cnt == '0) begin
                    in_lat   <= 1'b0;
                    in_beat  <= 1'b1;
                    beat_cnt <= '0;
                end else begin
                    lat_cnt <= lat_cnt - 1'b1;
                end
            end else if (last_beat) begin
                in_beat <= 1'b0;
            end else if (in_beat) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Shift out LSB first, or shift read bytes in from the top
    always_ff @(posedge CLK) begin
        if (burst.start)
            shreg <= burst.wdata;
        else if (in_beat)
            shreg <= {byte_in, shreg[`APB_DATA_W-1:`DDR_DQ_W]};
    end

    assign dq      = '{data: wr_beat ? shreg[`DDR_DQ_W-1:0] : '0, oe: wr_beat, dm: !wr_beat};
    assign rd_word = shreg;

endmodule

/* verilog/ddr_cmd_seq.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module ddr_cmd_seq (
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     req_valid,
    input  ddr_ctrl_pkg::mem_req_t   req,
    output logic                     req_ready,
    output logic                     req_done,
    input  logic                     ref_req,
    output logic                     ref_ack,
    output ddr_ctrl_pkg::burst_ctl_t burst,
    input  logic                     burst_done,
    output logic                     ddr_reset_n,
    output ddr_ctrl_pkg::ddr_cmd_t   cmd,
    output logic                     init_done
);

    import ddr_ctrl_pkg::*;

    // T_RFC is the longest wait
    localparam int CNT_W = $clog2(`T_RFC + 1);

    typedef enum logic [3:0] {
        S_RST_HOLD,     // DRAM reset low
        S_ZQ,
        S_ZQ_WAIT,
        S_IDLE,
        S_REF,
        S_RFC_WAIT,
        S_ACT,
        S_RCD_WAIT,
        S_COL,          // WR or RD, BC4
        S_BURST_WAIT    // PRE goes out with burst_done
    } seq_state_e;

    seq_state_e       state;
    seq_state_e       state_nx;
    logic [CNT_W-1:0] cnt;      // Shared wait counter
    mem_req_t         cur;      // Request in service
    ddr_cmd_e         cmd_sel;

    ////////////////////////////////////////////////////////////
    // State and wait counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state <= S_RST_HOLD;
            cnt   <= '0;
        end else begin
            state <= state_nx;
            cnt   <= (state_nx != state) ? '0 : cnt + 1'b1;    // Zero on entry
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && req_ready)
            cur <= req;
    end

    always_comb begin
        state_nx = state;
        case (state)
            S_RST_HOLD:   if (cnt == CNT_W'(`T_INIT_RST - 1)) state_nx = S_ZQ;
            S_ZQ:         state_nx = S_ZQ_WAIT;
            S_ZQ_WAIT:    if (cnt == CNT_W'(`T_ZQ - 2)) state_nx = S_IDLE;
            S_IDLE: begin
                if (ref_req)
                    state_nx = S_REF;           // Refresh first
                else if (req_valid)
                    state_nx = S_ACT;
            end
            S_REF:        state_nx = S_RFC_WAIT;
            S_RFC_WAIT:   if (cnt == CNT_W'(`T_RFC - 1)) state_nx = S_IDLE;
            S_ACT:        state_nx = S_RCD_WAIT;
            S_RCD_WAIT:   if (cnt == CNT_W'(`T_RCD - 2)) state_nx = S_COL;
            S_COL:        state_nx = S_BURST_WAIT;
            S_BURST_WAIT: if (burst_done) state_nx = S_IDLE;
            default:      state_nx = S_RST_HOLD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Command pins and address
    ////////////////////////////////////////////////////////////
    always_comb begin
        cmd_sel  = NOP;
        cmd.addr = '0;
        cmd.ba   = '0;
        case (state)
            S_ZQ: begin
                cmd_sel      = ZQCL;
                cmd.addr[10] = 1'b1;            // A10 high selects long ZQ
            end
            S_REF: cmd_sel = REF;
            S_ACT: begin
                cmd_sel  = ACT;
                cmd.addr = cur.row;
                cmd.ba   = cur.ba;
            end
            S_COL: begin
                cmd_sel  = cur.write ? WR : RD;
                cmd.addr = `DDR_ADDR_W'(cur.col);   // A10 and A12 low
                cmd.ba   = cur.ba;
            end
            S_BURST_WAIT: begin
                // Precharge of this bank right after the last beat
                if (burst_done) begin
                    cmd_sel = PRE;
                    cmd.ba  = cur.ba;
                end
            end
            default: ;
        endcase
        {cmd.cs_n, cmd.ras_n, cmd.cas_n, cmd.we_n} = cmd_sel;
        if (state == S_RST_HOLD)
            cmd.cs_n = 1'b1;                    // Deselected during reset
    end

    assign ddr_reset_n = (state != S_RST_HOLD);
    assign init_done   = !(state inside {S_RST_HOLD, S_ZQ, S_ZQ_WAIT});
    assign req_ready   = (state == S_IDLE) && !ref_req;
    assign ref_ack     = (state == S_REF);
    assign req_done    = (state == S_BURST_WAIT) && burst_done;

    // Burst launch with the column command
    assign burst = '{start: (state == S_COL), write: cur.write, wdata: cur.wdata};

endmodule

/* verilog/refresh_timer.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module refresh_timer (
    input  logic CLK,
    input  logic rst,
    input  logic init_done,
    output logic ref_req,
    input  logic ref_ack
);

    localparam int CNT_W = $clog2(`REF_INTERVAL);

    logic [CNT_W-1:0] cnt;

    // Interval count, frozen while a request waits
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            cnt     <= '0;
            ref_req <= 1'b0;
        end else if (ref_ack) begin
            cnt     <= '0;                      // Restart from the REF
            ref_req <= 1'b0;
        end else if (init_done && !ref_req) begin
            if (cnt == CNT_W'(`REF_INTERVAL - 1)) begin
                cnt     <= '0;
                ref_req <= 1'b1;                // Sticky until ack
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* verilog/apb_req_port.sv */
`timescale 1ns/1ps
`include "ddr_ctrl_params.svh"

module apb_req_port (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [`APB_ADDR_W-1:0]  paddr,
    input  logic [`APB_DATA_W-1:0]  pwdata,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic                    init_done,
    output logic                    req_valid,
    output ddr_ctrl_pkg::mem_req_t  req,
    input  logic                    req_ready,
    input  logic                    req_done,
    input  logic                    rd_valid,
    input  logic [`APB_DATA_W-1:0]  rd_word
);

    localparam int BA_LSB = 16;     // Bank field in REG_ROWBANK

    logic [`DDR_ROW_W-1:0]  row_q;
    logic [`DDR_BA_W-1:0]   ba_q;
    logic [`DDR_COL_W-1:0]  col_q;
    logic [`APB_DATA_W-1:0] wdata_q;
    logic [`APB_DATA_W-1:0] rdata_q;    // Word of the last read
    logic                   busy;       // Request outstanding
    logic                   access;
    logic                   addr_ok;
    logic                   wr_done;    // Write completing this cycle
    logic                   cmd_go;     // Command write completing

    assign access  = psel && penable;
    assign addr_ok = paddr inside {`REG_ROWBANK, `REG_COL, `REG_WDATA,
                                   `REG_CMD, `REG_STATUS, `REG_RDATA};

    // Stall only a command write while busy
    assign pready  = !(access && pwrite && (paddr == `REG_CMD) && busy);
    assign pslverr = access && !addr_ok;
    assign wr_done = access && pwrite && pready && addr_ok;
    assign cmd_go  = wr_done && (paddr == `REG_CMD);

    ////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////
    always_comb begin
        prdata = '0;
        case (paddr)
            `REG_ROWBANK: begin
                prdata[`DDR_ROW_W-1:0]      = row_q;
                prdata[BA_LSB +: `DDR_BA_W] = ba_q;
            end
            `REG_COL:    prdata[`DDR_COL_W-1:0] = col_q;
            `REG_WDATA:  prdata = wdata_q;
            `REG_STATUS: prdata[1:0] = {init_done, busy};
            `REG_RDATA:  prdata = rdata_q;
            default:     prdata = '0;   // CMD is write only
        endcase
    end

    // Registers, busy and request handshake
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            row_q     <= '0;
            ba_q      <= '0;
            col_q     <= '0;
            wdata_q   <= '0;
            rdata_q   <= '0;
            busy      <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            if (wr_done) begin
                case (paddr)
                    `REG_ROWBANK: begin
                        row_q <= pwdata[`DDR_ROW_W-1:0];
                        ba_q  <= pwdata[BA_LSB +: `DDR_BA_W];
                    end
                    `REG_COL:   col_q   <= pwdata[`DDR_COL_W-1:0];
                    `REG_WDATA: wdata_q <= pwdata;
                    default: ;                  // STATUS and RDATA read only
                endcase
            end
            if (cmd_go) begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end else begin
                if (req_valid && req_ready)
                    req_valid <= 1'b0;          // Taken by the sequencer
                if (req_done)
                    busy <= 1'b0;               // Precharge issued
            end
            if (rd_valid)
                rdata_q <= rd_word;
        end
    end

    // Request snapshot, stable while req_valid
    always_ff @(posedge CLK) begin
        if (cmd_go) begin
            req.write <= pwdata[0];
            req.ba    <= ba_q;
            req.row   <= row_q;
            req.col   <= col_q;
            req.wdata <= wdata_q;
        end
    end

endmodule

/* verilog/ddr_ctrl_pkg.sv */
`include "ddr_ctrl_params.svh"

package ddr_ctrl_pkg;

    // Encoding is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        NOP  = 4'b0111,
        ACT  = 4'b0011,
        WR   = 4'b0100,
        RD   = 4'b0101,
        PRE  = 4'b0010,
        REF  = 4'b0001,
        ZQCL = 4'b0110
    } ddr_cmd_e;

    // DRAM command pins, all strobes active low
    typedef struct packed {
        logic                   cs_n;
        logic                   ras_n;
        logic                   cas_n;
        logic                   we_n;
        logic [`DDR_ADDR_W-1:0] addr;
        logic [`DDR_BA_W-1:0]   ba;
    } ddr_cmd_t;

    // One host request
    typedef struct packed {
        logic                   write;
        logic [`DDR_BA_W-1:0]   ba;
        logic [`DDR_ROW_W-1:0]  row;
        logic [`DDR_COL_W-1:0]  col;
        logic [`APB_DATA_W-1:0] wdata;
    } mem_req_t;

    // Burst launch, start coincides with WR or RD
    typedef struct packed {
        logic                   start;
        logic                   write;
        logic [`APB_DATA_W-1:0] wdata;
    } burst_ctl_t;

    // Data pins of the byte lane
    typedef struct packed {
        logic [`DDR_DQ_W-1:0]   data;
        logic                   oe;     // Drive enable
        logic                   dm;     // High masks the byte
    } dq_bus_t;

endpackage

/* include/ddr_ctrl_params.svh */
`ifndef DDR_CTRL_PARAMS_SVH
`define DDR_CTRL_PARAMS_SVH

////////////////////////////////////////////////////////////
// DRAM geometry
////////////////////////////////////////////////////////////
`define DDR_ROW_W    15         // Row address bits
`define DDR_COL_W    10         // Column bits
`define DDR_BA_W     3          // Bank bits
`define DDR_ADDR_W   15         // Address pins A0..A14
`define DDR_DQ_W     8          // Single byte lane
`define DDR_BURST    4          // BC4 beats

// APB widths
`define APB_DATA_W   32
`define APB_ADDR_W   8

////////////////////////////////////////////////////////////
// Timing in controller clocks
////////////////////////////////////////////////////////////
`define T_INIT_RST   10         // DRAM reset held low
`define T_ZQ         16         // Wait after ZQCL
`define T_RCD        10         // ACT to column command
`define T_RFC        103        // Quiet time after REF
`define T_WL         7          // Write latency
`define T_RL         5          // Read latency
`define REF_INTERVAL 600        // Between refresh requests

// Register offsets
`define REG_ROWBANK  8'h00      // Row in [14:0], bank in [18:16]
`define REG_COL      8'h04
`define REG_WDATA    8'h08
`define REG_CMD      8'h0C      // Bit 0 set means write
`define REG_STATUS   8'h10      // Bit 0 busy, bit 1 init done
`define REG_RDATA    8'h14

`endif
